// ==== design/cdb_broadcast.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb_broadcast import fp_format_pkg::*, ooo_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  cdb_t     ext_result,
	output logic     ext_ready,
	input  logic     fmov_req_valid,
	input  rob_tag_t fmov_req_tag,
	output logic     fmov_req_ready,
	input  fp32_t    fmov_result,
	output cdb_t     cdb
);

	logic     grant_valid;
	logic     grant_ext;
	rob_tag_t grant_tag;
	fp32_t    ext_data;

	// Fixed priority, external producer never waits
	assign ext_ready      = 1'b1;
	assign fmov_req_ready = !ext_result.valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			grant_valid <= 1'b0;
			grant_ext   <= 1'b0;
		end else begin
			grant_valid <= ext_result.valid || fmov_req_valid;
			grant_ext   <= ext_result.valid;
		end
	end

	always_ff @(posedge clk) begin
		grant_tag <= ext_result.valid ? ext_result.tag : fmov_req_tag;
		if (ext_result.valid) begin
			ext_data <= ext_result.data;
		end
	end

	// Station data is already registered on its side
	always_comb begin
		cdb.valid = grant_valid;
		cdb.tag   = grant_tag;
		cdb.data  = grant_ext ? ext_data : fmov_result;
	end

endmodule

`default_nettype wire

// ==== design/fmov_station.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fmov_cfg.svh"

module fmov_station import fp_format_pkg::*, ooo_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  fmov_issue_t issue,
	input  logic        issue_valid,
	output logic        issue_ready,
	input  cdb_t        src_opd,
	input  cdb_t        cdb,
	output logic        fmov_req_valid,
	output rob_tag_t    fmov_req_tag,
	input  logic        fmov_req_ready,
	output fp32_t       fmov_result
);

	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		fmov_op_t op;
		cdb_t     opd; // valid means captured, tag is the awaited producer
	} entry_t;

	entry_t e     [`FMOV_N_ENTRY]; // Compacted toward 0, entry 0 oldest
	entry_t e_upd [`FMOV_N_ENTRY];
	entry_t e_new;
	logic [2:0] ready_vec;
	logic dispatch;
	fp32_t sel_data;

	// Wakeup from the CDB, sign applied on capture
	always_comb begin
		for (int i = 0; i < `FMOV_N_ENTRY; i++) begin
			e_upd[i] = e[i];
			if (!e[i].opd.valid && cdb.valid && cdb.tag == e[i].opd.tag) begin
				e_upd[i].opd.valid = 1'b1;
				e_upd[i].opd.data  = apply_sign(e[i].op, cdb.data);
			end
		end
	end

	// src_opd already carries the CDB bypass
	always_comb begin
		e_new.valid     = issue_valid;
		e_new.tag       = issue.tag;
		e_new.op        = issue.op;
		e_new.opd.valid = src_opd.valid;
		e_new.opd.tag   = src_opd.tag;
		e_new.opd.data  = apply_sign(issue.op, src_opd.data);
	end

	assign ready_vec[0] = e_upd[0].valid && e_upd[0].opd.valid;
	assign ready_vec[1] = e_upd[1].valid && e_upd[1].opd.valid;
	assign ready_vec[2] = e_new.valid && e_new.opd.valid;

	// Oldest ready first
	always_comb begin
		if (ready_vec[0]) begin
			fmov_req_tag = e_upd[0].tag;
			sel_data     = e_upd[0].opd.data;
		end else if (ready_vec[1]) begin
			fmov_req_tag = e_upd[1].tag;
			sel_data     = e_upd[1].opd.data;
		end else begin
			fmov_req_tag = e_new.tag;
			sel_data     = e_new.opd.data;
		end
	end

	assign fmov_req_valid = |ready_vec;
	assign dispatch       = fmov_req_valid && fmov_req_ready;
	assign issue_ready    = dispatch || !e[`FMOV_N_ENTRY-1].valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			e[0] <= '0;
			e[1] <= '0;
		end else if (dispatch) begin
			if (ready_vec[0]) begin
				// Shift down, new issue goes behind
				e[0] <= e[1].valid ? e_upd[1] : e_new;
				e[1] <= e[1].valid ? e_new : '0;
			end else if (ready_vec[1]) begin
				e[0] <= e_upd[0];
				e[1] <= e_new;
			end else begin
				e[0] <= e_upd[0]; // Issue went straight out
				e[1] <= e_upd[1];
			end
		end else begin
			e[0] <= e[0].valid ? e_upd[0] : e_new;
			e[1] <= e[1].valid ? e_upd[1] : (e[0].valid ? e_new : '0);
		end
	end

	// Result lines up with the CDB beat after the grant
	always_ff @(posedge clk) begin
		if (dispatch) begin
			fmov_result <= sel_data;
		end
	end

endmodule

`default_nettype wire

// ==== design/fmov_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fmov_unit_top import fp_format_pkg::*, ooo_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  fmov_issue_t issue,
	input  logic        issue_valid,
	output logic        issue_ready,
	input  arch_write_t arch_write,
	input  cdb_t        ext_result,
	output logic        ext_ready,
	output cdb_t        cdb
);

	cdb_t     src_opd;
	logic     issue_fire;
	logic     fmov_req_valid;
	logic     fmov_req_ready;
	rob_tag_t fmov_req_tag;
	fp32_t    fmov_result;

	assign issue_fire = issue_valid && issue_ready;

	fpr_status u_fpr_status (
		.clk        (clk),
		.reset      (reset),
		.issue      (issue),
		.issue_fire (issue_fire),
		.arch_write (arch_write),
		.cdb        (cdb),
		.src_opd    (src_opd)
	);

	fmov_station u_fmov_station (
		.clk            (clk),
		.reset          (reset),
		.issue          (issue),
		.issue_valid    (issue_valid),
		.issue_ready    (issue_ready),
		.src_opd        (src_opd),
		.cdb            (cdb),
		.fmov_req_valid (fmov_req_valid),
		.fmov_req_tag   (fmov_req_tag),
		.fmov_req_ready (fmov_req_ready),
		.fmov_result    (fmov_result)
	);

	// Bus is fed back to the status table and the station
	cdb_broadcast u_cdb_broadcast (
		.clk            (clk),
		.reset          (reset),
		.ext_result     (ext_result),
		.ext_ready      (ext_ready),
		.fmov_req_valid (fmov_req_valid),
		.fmov_req_tag   (fmov_req_tag),
		.fmov_req_ready (fmov_req_ready),
		.fmov_result    (fmov_result),
		.cdb            (cdb)
	);

endmodule

`default_nettype wire

// ==== design/fp_format_pkg.sv ====
`default_nettype none

package fp_format_pkg;

	localparam int FP32_EXP_W = 8;
	localparam int FP32_MAN_W = 23;

	typedef struct packed {
		logic                  sign;
		logic [FP32_EXP_W-1:0] exponent;
		logic [FP32_MAN_W-1:0] mantissa;
	} fp32_t;

	typedef struct packed {
		logic is_fabs;
		logic is_fneg;
	} fmov_op_t;

	// Only the sign bit is touched
	function automatic fp32_t apply_sign(fmov_op_t op, fp32_t d);
		fp32_t r;
		r = d;
		case ({op.is_fabs, op.is_fneg})
			2'b00: r.sign = d.sign;   // FMV
			2'b01: r.sign = !d.sign;  // FNEG
			2'b10: r.sign = 1'b0;     // FABS
			default: r.sign = 1'b1;   // FNABS
		endcase
		return r;
	endfunction

endpackage

`default_nettype wire

// ==== design/fpr_status.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fmov_cfg.svh"

module fpr_status import fp_format_pkg::*, ooo_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  fmov_issue_t issue,
	input  logic        issue_fire,
	input  arch_write_t arch_write,
	input  cdb_t        cdb,
	output cdb_t        src_opd
);

	fp32_t    value    [`FMOV_N_FPR];
	rob_tag_t pend_tag [`FMOV_N_FPR];
	logic [`FMOV_N_FPR-1:0] pending;
	logic [`FMOV_N_FPR-1:0] cdb_hit;

	// A register waiting on the tag now on the bus
	always_comb begin
		for (int i = 0; i < `FMOV_N_FPR; i++) begin
			cdb_hit[i] = cdb.valid && pending[i] && (pend_tag[i] == cdb.tag);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
		end else begin
			for (int i = 0; i < `FMOV_N_FPR; i++) begin
				if (issue_fire && issue.dst == fpr_idx_t'(i)) begin
					pending[i] <= 1'b1; // New producer wins over any clear
				end else if (arch_write.valid && arch_write.idx == fpr_idx_t'(i)) begin
					pending[i] <= 1'b0;
				end else if (cdb_hit[i]) begin
					pending[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `FMOV_N_FPR; i++) begin
			if (issue_fire && issue.dst == fpr_idx_t'(i)) begin
				pend_tag[i] <= issue.tag;
			end
		end
	end

	// Register values
	always_ff @(posedge clk) begin
		for (int i = 0; i < `FMOV_N_FPR; i++) begin
			if (arch_write.valid && arch_write.idx == fpr_idx_t'(i)) begin
				value[i] <= arch_write.data;
			end else if (cdb_hit[i]) begin
				value[i] <= cdb.data;
			end
		end
	end

	// Source read sees state before this cycle's issue marks it
	always_comb begin
		src_opd.valid = !pending[issue.src] || cdb_hit[issue.src];
		src_opd.tag   = pend_tag[issue.src];
		src_opd.data  = cdb_hit[issue.src] ? cdb.data : value[issue.src];
	end

endmodule

`default_nettype wire

// ==== design/ooo_pkg.sv ====
`default_nettype none
`include "fmov_cfg.svh"

package ooo_pkg;
	import fp_format_pkg::*;

	localparam int FPR_IDX_W = $clog2(`FMOV_N_FPR);

	typedef logic [`FMOV_TAG_WIDTH-1:0] rob_tag_t;
	typedef logic [FPR_IDX_W-1:0] fpr_idx_t;

	// CDB beat, also used for operand reads
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		fp32_t    data;
	} cdb_t;

	typedef struct packed {
		fmov_op_t op;
		fpr_idx_t src;
		fpr_idx_t dst;
		rob_tag_t tag;
	} fmov_issue_t;

	// Direct register load
	typedef struct packed {
		logic     valid;
		fpr_idx_t idx;
		fp32_t    data;
	} arch_write_t;

endpackage

`default_nettype wire

// ==== include/fmov_cfg.svh ====
`ifndef FMOV_CFG_SVH
`define FMOV_CFG_SVH

// Reorder buffer tag width
`define FMOV_TAG_WIDTH 4

// Architectural FP registers
`define FMOV_N_FPR 8

// Station depth, compaction logic assumes two
`define FMOV_N_ENTRY 2

`endif

// ==== project.f ====
+incdir+include
design/fp_format_pkg.sv
design/ooo_pkg.sv
design/fpr_status.sv
design/fmov_station.sv
design/cdb_broadcast.sv
design/fmov_unit_top.sv
tb/fmov_unit_tb.sv

// ==== tb/fmov_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fmov_cfg.svh"

module fmov_unit_tb import fp_format_pkg::*, ooo_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int N_TESTS    = 6;
	localparam int N_TAGS     = 1 << `FMOV_TAG_WIDTH;
	localparam rob_tag_t IDLE_TAG = rob_tag_t'(N_TAGS - 1); // Nobody ever waits on it

	logic        clk;
	logic        reset;
	fmov_issue_t issue;
	logic        issue_valid;
	logic        issue_ready;
	arch_write_t arch_write;
	cdb_t        ext_result;
	logic        ext_ready;
	cdb_t        cdb;

	fp32_t model_val [`FMOV_N_FPR]; // Value once the last producer has broadcast
	fp32_t exp_data  [N_TAGS];
	fp32_t seen_data [N_TAGS];      // Data of the first beat per tag
	int    seen_cnt  [N_TAGS];
	int    first_pos [N_TAGS];
	int    n_beats;
	int    cyc;
	int    errors;
	int    checks;
	int    tests_run;

	fmov_unit_top dut (
		.clk         (clk),
		.reset       (reset),
		.issue       (issue),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.arch_write  (arch_write),
		.ext_result  (ext_result),
		.ext_ready   (ext_ready),
		.cdb         (cdb)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	// Bus monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (!reset && cdb.valid) begin
			if (seen_cnt[cdb.tag] == 0) begin
				seen_data[cdb.tag] = cdb.data;
				first_pos[cdb.tag] = n_beats;
			end
			seen_cnt[cdb.tag]++;
			n_beats++;
		end
	end

	initial begin
		#(N_TESTS * 400 * CLK_PERIOD);
		$display("Timeout: simulation still running after %0d cycles", N_TESTS * 400);
		$display("Regression failed");
		$finish;
	end

	// FMV keeps, FNEG flips, FABS clears, both flags force a one
	function automatic fp32_t expect_sign(fmov_op_t op, fp32_t d);
		fp32_t r;
		r = d;
		if (op.is_fabs)
			r.sign = op.is_fneg;
		else
			r.sign = d.sign ^ op.is_fneg;
		return r;
	endfunction

	task automatic check_that(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("[FAIL] %t: %s", $time, msg);
		end
	endtask

	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	task automatic clear_log;
		for (int i = 0; i < N_TAGS; i++) begin
			seen_cnt[i]  = 0;
			first_pos[i] = -1;
		end
		n_beats = 0;
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		$display("%-24s %s", name, (errors == errs_before) ? "ok" : "FAILED");
	endtask

	task automatic load_reg(input fpr_idx_t idx, input fp32_t data);
		arch_write.valid = 1'b1;
		arch_write.idx   = idx;
		arch_write.data  = data;
		next_cycle();
		arch_write.valid = 1'b0;
		model_val[idx] = data;
	endtask

	task automatic issue_op(input fmov_op_t op, input fpr_idx_t src, input fpr_idx_t dst,
			input rob_tag_t tag, output int fire_cyc);
		int n;
		n = 0;
		issue.op    = op;
		issue.src   = src;
		issue.dst   = dst;
		issue.tag   = tag;
		issue_valid = 1'b1;
		@(negedge clk);
		while (!issue_ready && n < 100) begin
			next_cycle();
			@(negedge clk);
			n++;
		end
		check_that(issue_ready, $sformatf("issue of tag %0d was never accepted", tag));
		fire_cyc = cyc;
		exp_data[tag]  = expect_sign(op, model_val[src]); // Source read before dst marked
		model_val[dst] = exp_data[tag];
		next_cycle();
		issue_valid = 1'b0;
	endtask

	task automatic ext_pulse(input rob_tag_t tag, input fp32_t data);
		ext_result.valid = 1'b1;
		ext_result.tag   = tag;
		ext_result.data  = data;
		exp_data[tag]    = data;
		next_cycle();
		ext_result.valid = 1'b0;
	endtask

	task automatic wait_tag(input rob_tag_t tag);
		int n;
		n = 0;
		while (seen_cnt[tag] == 0 && n < 200) begin
			next_cycle();
			n++;
		end
		check_that(seen_cnt[tag] != 0, $sformatf("tag %0d was never broadcast", tag));
	endtask

	task automatic check_beat(input rob_tag_t tag, input fp32_t data, input int due_cyc);
		@(negedge clk);
		check_that(cdb.valid && cdb.tag == tag && cyc == due_cyc,
			$sformatf("no beat for tag %0d in cycle %0d (valid %0b tag %0d)",
			tag, due_cyc, cdb.valid, cdb.tag));
		check_that(cdb.data == data,
			$sformatf("tag %0d data %h, expected %h", tag, cdb.data, data));
		next_cycle();
	endtask

	task automatic after_reset;
		int e0;
		e0 = errors;
		@(negedge clk);
		check_that(!cdb.valid, "cdb valid after reset");
		check_that(issue_ready && ext_ready, "issue_ready or ext_ready low after reset");
		next_cycle();
		report_test("after_reset", e0);
	endtask

	task automatic sign_ops_ready_src;
		int e0;
		int fc;
		e0 = errors;
		for (int i = 0; i < `FMOV_N_FPR; i++) begin
			load_reg(fpr_idx_t'(i), fp32_t'($urandom));
		end
		for (int k = 0; k < 4; k++) begin
			issue_op(fmov_op_t'(2'(k)), fpr_idx_t'(k), fpr_idx_t'(k + 4), rob_tag_t'(k), fc);
			check_beat(rob_tag_t'(k), exp_data[k], fc + 1);
		end
		report_test("sign_ops_ready_src", e0);
	endtask

	task automatic wakeup_from_external;
		int e0;
		int fc;
		fmov_op_t op_y;
		fp32_t d;
		e0 = errors;
		clear_log();
		d    = fp32_t'($urandom);
		op_y = fmov_op_t'(2'($urandom));
		ext_result.valid = 1'b1; // Hold the bus so tag 8 stays in the station
		ext_result.tag   = IDLE_TAG;
		ext_result.data  = fp32_t'($urandom);
		issue_op(fmov_op_t'(2'b00), 0, 6, 8, fc);
		issue_op(op_y, 6, 7, 9, fc);
		repeat (3) next_cycle();
		ext_result.tag  = 8;
		ext_result.data = d;
		next_cycle();
		ext_result.valid = 1'b0;
		model_val[6] = d;
		exp_data[9]  = expect_sign(op_y, d);
		model_val[7] = exp_data[9];
		wait_tag(9);
		check_that(seen_data[8] == d, "external beat for tag 8 carried wrong data");
		check_that(seen_data[9] == exp_data[9],
			$sformatf("tag 9 data %h, expected %h", seen_data[9], exp_data[9]));
		issue_op(fmov_op_t'(2'b00), 7, 5, 10, fc); // Read back the destination
		wait_tag(10);
		check_that(seen_data[10] == exp_data[10],
			$sformatf("register 7 holds %h, expected %h", seen_data[10], exp_data[10]));
		report_test("wakeup_from_external", e0);
	endtask

	task automatic external_latency;
		int e0;
		int rc;
		fp32_t d;
		e0 = errors;
		for (int k = 0; k < 3; k++) begin
			d = fp32_t'($urandom);
			ext_result.valid = 1'b1;
			ext_result.tag   = rob_tag_t'(11 + k);
			ext_result.data  = d;
			@(negedge clk);
			rc = cyc;
			next_cycle();
			ext_result.valid = 1'b0;
			check_beat(rob_tag_t'(11 + k), d, rc + 1);
		end
		report_test("external_latency", e0);
	endtask

	task automatic backpressure_order;
		int e0;
		int fc;
		e0 = errors;
		clear_log();
		ext_result.valid = 1'b1;
		ext_result.tag   = IDLE_TAG;
		ext_result.data  = fp32_t'($urandom);
		issue_op(fmov_op_t'(2'($urandom)), 1, 2, 0, fc);
		issue_op(fmov_op_t'(2'($urandom)), 3, 4, 1, fc);
		repeat (2) begin
			@(negedge clk);
			check_that(!issue_ready, "issue_ready high with a full station");
			next_cycle();
		end
		ext_result.valid = 1'b0;
		wait_tag(0);
		wait_tag(1);
		check_that(first_pos[0] < first_pos[1], "results left the station out of issue order");
		for (int t = 0; t < 2; t++) begin
			check_that(seen_data[t] == exp_data[t],
				$sformatf("tag %0d data %h, expected %h", t, seen_data[t], exp_data[t]));
		end
		report_test("backpressure_order", e0);
	endtask

	task automatic random_mix;
		int e0;
		int fc;
		int n_op;
		int n_ext;
		e0 = errors;
		n_op  = 0;
		n_ext = 0;
		clear_log();
		// Station tags 0 to 9, external tags 10 to 14
		while (n_op < 10 || n_ext < 5) begin
			if (n_ext < 5 && ($urandom % 3 == 0 || n_op == 10)) begin
				ext_pulse(rob_tag_t'(10 + n_ext), fp32_t'($urandom));
				n_ext++;
			end else begin
				issue_op(fmov_op_t'(2'($urandom)), fpr_idx_t'($urandom), fpr_idx_t'($urandom),
					rob_tag_t'(n_op), fc);
				n_op++;
			end
		end
		for (int t = 0; t < 15; t++) begin
			wait_tag(rob_tag_t'(t));
		end
		repeat (4) next_cycle(); // Catch late duplicates
		for (int t = 0; t < 15; t++) begin
			check_that(seen_cnt[t] == 1, $sformatf("tag %0d seen %0d times", t, seen_cnt[t]));
			check_that(seen_data[t] == exp_data[t],
				$sformatf("tag %0d data %h, expected %h", t, seen_data[t], exp_data[t]));
		end
		check_that(n_beats == 15, $sformatf("%0d beats on the bus, expected 15", n_beats));
		report_test("random_mix", e0);
	endtask

	initial begin
		void'($urandom(32'hb21d_1891));
		$timeformat(-9, 1, " ns", 0);
		errors      = 0;
		checks      = 0;
		tests_run   = 0;
		cyc         = 0;
		reset       = 1'b1;
		issue       = '0;
		issue_valid = 1'b0;
		arch_write  = '0;
		ext_result  = '0;
		clear_log();
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		after_reset();
		sign_ops_ready_src();
		wakeup_from_external();
		external_latency();
		backpressure_order();
		random_mix();
		$display("Tests: %0d  checks: %0d  errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
